// File: design/alu_defines.svh
/* Integer ALU datapath definitions
   Widths and bit positions in the op-flag vector */
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Data and adder widths
`define ALU_XLEN     32
// One extra adder bit holds the sign for compares
`define ALU_ADDER_W  33
`define ALU_SHAMT_W  5

// Op-flag vector width, positions 22 to 24 are spare
`define ALU_OP_NUM   25

// Op-flag positions, also the op codes of the vector file
`define ALU_OP_ADD      0
`define ALU_OP_SUB      1
`define ALU_OP_OR       2
`define ALU_OP_XOR      3
`define ALU_OP_AND      4
`define ALU_OP_SLL      5
`define ALU_OP_SRL      6
`define ALU_OP_SRA      7
`define ALU_OP_SLT      8
`define ALU_OP_SLTU     9
`define ALU_OP_MVOP2    10
`define ALU_OP_MAX      11
`define ALU_OP_MIN      12
`define ALU_OP_MAXU     13
`define ALU_OP_MINU     14
`define ALU_OP_DOT      15
`define ALU_OP_CMP_EQ   16
`define ALU_OP_CMP_NE   17
`define ALU_OP_CMP_LT   18
`define ALU_OP_CMP_GT   19
`define ALU_OP_CMP_LTU  20
`define ALU_OP_CMP_GTU  21

`endif

// File: design/alu_pkg.sv
/* Integer ALU datapath types
   op2 read as a full operand or as a shift amount */
`include "alu_defines.svh"

package alu_pkg;

  //////////////////////////////////////////////////
  // Second operand
  //////////////////////////////////////////////////

  // Full word for the adder, logic ops and mvop2
  // Low bits alone for the shifter
  typedef union packed {
    logic [`ALU_XLEN-1:0] word;
    struct packed {
      // Ignored by the shifter
      logic [`ALU_XLEN-`ALU_SHAMT_W-1:0] unused;
      logic [`ALU_SHAMT_W-1:0]           shamt;
    } sh;
  } op2_u;

endpackage

// File: design/alu_req_mux.sv
/* Requestor mux
   Merges ALU, BJP and AGU requests into one operand pair and op-flag vector */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_req_mux (
  // Regular ALU
  input  logic                   alu_req,
  input  logic                   alu_add,
  input  logic                   alu_sub,
  input  logic                   alu_xor,
  input  logic                   alu_sll,
  input  logic                   alu_srl,
  input  logic                   alu_sra,
  input  logic                   alu_or,
  input  logic                   alu_and,
  input  logic                   alu_slt,
  input  logic                   alu_sltu,
  input  logic                   alu_lui,
  input  logic                   alu_dot,
  input  logic [`ALU_XLEN-1:0]   alu_op1,
  input  logic [`ALU_XLEN-1:0]   alu_op2,
  // Branch unit
  input  logic                   bjp_req,
  input  logic [`ALU_XLEN-1:0]   bjp_op1,
  input  logic [`ALU_XLEN-1:0]   bjp_op2,
  input  logic                   bjp_add,
  input  logic                   bjp_cmp_eq,
  input  logic                   bjp_cmp_ne,
  input  logic                   bjp_cmp_lt,
  input  logic                   bjp_cmp_gt,
  input  logic                   bjp_cmp_ltu,
  input  logic                   bjp_cmp_gtu,
  // Address unit
  input  logic                   agu_req,
  input  logic [`ALU_XLEN-1:0]   agu_op1,
  input  logic [`ALU_XLEN-1:0]   agu_op2,
  input  logic                   agu_swap,
  input  logic                   agu_add,
  input  logic                   agu_and,
  input  logic                   agu_or,
  input  logic                   agu_xor,
  input  logic                   agu_max,
  input  logic                   agu_min,
  input  logic                   agu_maxu,
  input  logic                   agu_minu,
  // To the function units
  output logic [`ALU_XLEN-1:0]   mux_op1,
  output alu_pkg::op2_u          mux_op2,
  output logic [`ALU_OP_NUM-1:0] op_flags
);

  logic [`ALU_OP_NUM-1:0] alu_flags;
  logic [`ALU_OP_NUM-1:0] bjp_flags;
  logic [`ALU_OP_NUM-1:0] agu_flags;

  //////////////////////////////////////////////////
  // Per-requestor flag vectors
  //////////////////////////////////////////////////

  always_comb begin
    alu_flags = '0;
    alu_flags[`ALU_OP_ADD]   = alu_add;
    alu_flags[`ALU_OP_SUB]   = alu_sub;
    alu_flags[`ALU_OP_XOR]   = alu_xor;
    alu_flags[`ALU_OP_SLL]   = alu_sll;
    alu_flags[`ALU_OP_SRL]   = alu_srl;
    alu_flags[`ALU_OP_SRA]   = alu_sra;
    alu_flags[`ALU_OP_OR]    = alu_or;
    alu_flags[`ALU_OP_AND]   = alu_and;
    alu_flags[`ALU_OP_SLT]   = alu_slt;
    alu_flags[`ALU_OP_SLTU]  = alu_sltu;
    // LUI only moves the immediate in op2
    alu_flags[`ALU_OP_MVOP2] = alu_lui;
    alu_flags[`ALU_OP_DOT]   = alu_dot;
  end

  always_comb begin
    bjp_flags = '0;
    // Branch target add shares the plain add
    bjp_flags[`ALU_OP_ADD]     = bjp_add;
    bjp_flags[`ALU_OP_CMP_EQ]  = bjp_cmp_eq;
    bjp_flags[`ALU_OP_CMP_NE]  = bjp_cmp_ne;
    bjp_flags[`ALU_OP_CMP_LT]  = bjp_cmp_lt;
    bjp_flags[`ALU_OP_CMP_GT]  = bjp_cmp_gt;
    bjp_flags[`ALU_OP_CMP_LTU] = bjp_cmp_ltu;
    bjp_flags[`ALU_OP_CMP_GTU] = bjp_cmp_gtu;
  end

  always_comb begin
    agu_flags = '0;
    // Swap returns op2 unchanged
    agu_flags[`ALU_OP_MVOP2] = agu_swap;
    agu_flags[`ALU_OP_ADD]   = agu_add;
    agu_flags[`ALU_OP_AND]   = agu_and;
    agu_flags[`ALU_OP_OR]    = agu_or;
    agu_flags[`ALU_OP_XOR]   = agu_xor;
    agu_flags[`ALU_OP_MAX]   = agu_max;
    agu_flags[`ALU_OP_MIN]   = agu_min;
    agu_flags[`ALU_OP_MAXU]  = agu_maxu;
    agu_flags[`ALU_OP_MINU]  = agu_minu;
  end

  //////////////////////////////////////////////////
  // AND-OR select, all zero with no requestor
  //////////////////////////////////////////////////

  assign mux_op1 = ({`ALU_XLEN{alu_req}} & alu_op1)
                 | ({`ALU_XLEN{bjp_req}} & bjp_op1)
                 | ({`ALU_XLEN{agu_req}} & agu_op1);

  assign mux_op2.word = ({`ALU_XLEN{alu_req}} & alu_op2)
                      | ({`ALU_XLEN{bjp_req}} & bjp_op2)
                      | ({`ALU_XLEN{agu_req}} & agu_op2);

  assign op_flags = ({`ALU_OP_NUM{alu_req}} & alu_flags)
                  | ({`ALU_OP_NUM{bjp_req}} & bjp_flags)
                  | ({`ALU_OP_NUM{agu_req}} & agu_flags);

endmodule

// File: design/alu_shifter.sv
/* Shared shifter
   One left shifter with bit reversal covers sll, srl and sra */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_shifter (
  input  logic [`ALU_XLEN-1:0]   mux_op1,
  input  alu_pkg::op2_u          mux_op2,
  input  logic [`ALU_OP_NUM-1:0] op_flags,
  output logic [`ALU_XLEN-1:0]   shift_res
);

  logic                    op_sll;
  logic                    op_srl;
  logic                    op_sra;
  logic                    op_right;
  logic                    op_shift;
  logic [`ALU_XLEN-1:0]    op1_gated;
  logic [`ALU_XLEN-1:0]    op1_rev;
  logic [`ALU_XLEN-1:0]    shifter_in1;
  logic [`ALU_SHAMT_W-1:0] shifter_in2;
  logic [`ALU_XLEN-1:0]    shifter_out;
  logic [`ALU_XLEN-1:0]    srl_res;
  logic [`ALU_XLEN-1:0]    sra_res;
  logic [`ALU_XLEN-1:0]    eff_mask;

  assign op_sll   = op_flags[`ALU_OP_SLL];
  assign op_srl   = op_flags[`ALU_OP_SRL];
  assign op_sra   = op_flags[`ALU_OP_SRA];
  assign op_right = op_srl | op_sra;
  assign op_shift = op_sll | op_right;

  // Inputs held at zero unless a shift is requested
  assign op1_gated   = {`ALU_XLEN{op_shift}} & mux_op1;
  assign shifter_in2 = {`ALU_SHAMT_W{op_shift}} & mux_op2.sh.shamt;

  // Right shift as left shift of the reversed word
  assign op1_rev     = {<<{op1_gated}};
  assign shifter_in1 = op_right ? op1_rev : op1_gated;
  assign shifter_out = shifter_in1 << shifter_in2;
  assign srl_res     = {<<{shifter_out}};

  // Mask marks the bits kept from srl, sign fills the rest
  assign eff_mask = {`ALU_XLEN{1'b1}} >> shifter_in2;
  assign sra_res  = (srl_res & eff_mask)
                  | ({`ALU_XLEN{op1_gated[`ALU_XLEN-1]}} & ~eff_mask);

  assign shift_res = ({`ALU_XLEN{op_sll}} & shifter_out)
                   | ({`ALU_XLEN{op_srl}} & srl_res)
                   | ({`ALU_XLEN{op_sra}} & sra_res);

endmodule

// File: design/alu_adder.sv
/* Shared 33-bit adder
   Serves add, sub, the compares, slt and max/min */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_adder (
  input  logic [`ALU_XLEN-1:0]    mux_op1,
  input  alu_pkg::op2_u           mux_op2,
  input  logic [`ALU_OP_NUM-1:0]  op_flags,
  output logic [`ALU_ADDER_W-1:0] adder_res
);

  localparam int EXT_W = `ALU_ADDER_W - `ALU_XLEN;

  logic                    op_unsigned;
  logic                    adder_sub;
  logic                    adder_on;
  logic [`ALU_ADDER_W-1:0] adder_op1;
  logic [`ALU_ADDER_W-1:0] adder_op2;
  logic [`ALU_ADDER_W-1:0] adder_in1;
  logic [`ALU_ADDER_W-1:0] adder_in2;

  // Zero extension for the unsigned orders
  assign op_unsigned = op_flags[`ALU_OP_SLTU] | op_flags[`ALU_OP_CMP_LTU]
                     | op_flags[`ALU_OP_CMP_GTU] | op_flags[`ALU_OP_MAXU]
                     | op_flags[`ALU_OP_MINU];

  // Every ordering op is a subtract, sign bit gives less-than
  assign adder_sub = op_flags[`ALU_OP_SUB]
                   | op_flags[`ALU_OP_CMP_LT] | op_flags[`ALU_OP_CMP_GT]
                   | op_flags[`ALU_OP_CMP_LTU] | op_flags[`ALU_OP_CMP_GTU]
                   | op_flags[`ALU_OP_MAX] | op_flags[`ALU_OP_MIN]
                   | op_flags[`ALU_OP_MAXU] | op_flags[`ALU_OP_MINU]
                   | op_flags[`ALU_OP_SLT] | op_flags[`ALU_OP_SLTU];

  assign adder_on = op_flags[`ALU_OP_ADD] | adder_sub;

  assign adder_op1 = {{EXT_W{~op_unsigned & mux_op1[`ALU_XLEN-1]}}, mux_op1};
  assign adder_op2 = {{EXT_W{~op_unsigned & mux_op2.word[`ALU_XLEN-1]}}, mux_op2.word};

  // Gated off when idle, op2 inverted plus carry for subtract
  assign adder_in1 = {`ALU_ADDER_W{adder_on}} & adder_op1;
  assign adder_in2 = {`ALU_ADDER_W{adder_on}} & (adder_sub ? ~adder_op2 : adder_op2);

  assign adder_res = adder_in1 + adder_in2 + {{(`ALU_ADDER_W-1){1'b0}}, adder_sub};

endmodule

// File: design/alu_dot_unit.sv
/* Dot product unit
   a0*a4 + a1*a5 + a2*a6 + a3*a7, kept to 32 bits */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_dot_unit (
  input  logic [`ALU_XLEN-1:0]   dot_a0,
  input  logic [`ALU_XLEN-1:0]   dot_a1,
  input  logic [`ALU_XLEN-1:0]   dot_a2,
  input  logic [`ALU_XLEN-1:0]   dot_a3,
  input  logic [`ALU_XLEN-1:0]   dot_a4,
  input  logic [`ALU_XLEN-1:0]   dot_a5,
  input  logic [`ALU_XLEN-1:0]   dot_a6,
  input  logic [`ALU_XLEN-1:0]   dot_a7,
  input  logic [`ALU_OP_NUM-1:0] op_flags,
  output logic [`ALU_XLEN-1:0]   dot_res
);

  logic                 op_dot;
  logic [`ALU_XLEN-1:0] dot_in [8];
  logic [`ALU_XLEN-1:0] prod [4];
  logic [`ALU_XLEN-1:0] sum_01;
  logic [`ALU_XLEN-1:0] sum_23;

  assign op_dot = op_flags[`ALU_OP_DOT];

  // Multipliers idle at zero for every other op
  assign dot_in[0] = {`ALU_XLEN{op_dot}} & dot_a0;
  assign dot_in[1] = {`ALU_XLEN{op_dot}} & dot_a1;
  assign dot_in[2] = {`ALU_XLEN{op_dot}} & dot_a2;
  assign dot_in[3] = {`ALU_XLEN{op_dot}} & dot_a3;
  assign dot_in[4] = {`ALU_XLEN{op_dot}} & dot_a4;
  assign dot_in[5] = {`ALU_XLEN{op_dot}} & dot_a5;
  assign dot_in[6] = {`ALU_XLEN{op_dot}} & dot_a6;
  assign dot_in[7] = {`ALU_XLEN{op_dot}} & dot_a7;

  // Low word of each product only
  for (genvar i = 0; i < 4; i++) begin : g_mul
    assign prod[i] = dot_in[i] * dot_in[i+4];
  end

  // Two-level adder tree
  assign sum_01  = prod[0] + prod[1];
  assign sum_23  = prod[2] + prod[3];
  assign dot_res = sum_01 + sum_23;

endmodule

// File: design/alu_result_mux.sv
/* Result mux
   Logic ops, compares, slt, max/min and the final AND-OR select */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_result_mux (
  input  logic [`ALU_XLEN-1:0]    mux_op1,
  input  alu_pkg::op2_u           mux_op2,
  input  logic [`ALU_OP_NUM-1:0]  op_flags,
  input  logic [`ALU_XLEN-1:0]    shift_res,
  input  logic [`ALU_ADDER_W-1:0] adder_res,
  input  logic [`ALU_XLEN-1:0]    dot_res,
  output logic [`ALU_XLEN-1:0]    dpath_res,
  output logic                    cmp_res
);

  logic                 xorer_on;
  logic [`ALU_XLEN-1:0] xorer_res;
  logic                 neq;
  logic                 op1_lt_op2;
  logic                 op_maxmin;
  logic                 maxmin_sel_op1;
  logic [`ALU_XLEN-1:0] maxmin_res;
  logic                 op_slttu;
  logic                 op_shift;

  //////////////////////////////////////////////////
  // XOR unit and compares
  //////////////////////////////////////////////////

  // Shared by xor and eq/ne
  assign xorer_on  = op_flags[`ALU_OP_XOR] | op_flags[`ALU_OP_CMP_EQ]
                   | op_flags[`ALU_OP_CMP_NE];
  assign xorer_res = {`ALU_XLEN{xorer_on}} & (mux_op1 ^ mux_op2.word);
  assign neq       = |xorer_res;

  // Adder sign bit is the less-than, signed or unsigned
  assign op1_lt_op2 = adder_res[`ALU_XLEN];

  assign cmp_res = (op_flags[`ALU_OP_CMP_EQ]  & ~neq)
                 | (op_flags[`ALU_OP_CMP_NE]  & neq)
                 | (op_flags[`ALU_OP_CMP_LT]  & op1_lt_op2)
                 | (op_flags[`ALU_OP_CMP_LTU] & op1_lt_op2)
                 | (op_flags[`ALU_OP_CMP_GT]  & ~op1_lt_op2)
                 | (op_flags[`ALU_OP_CMP_GTU] & ~op1_lt_op2);

  //////////////////////////////////////////////////
  // Max/min, slt and shift selects
  //////////////////////////////////////////////////

  assign op_maxmin = op_flags[`ALU_OP_MAX] | op_flags[`ALU_OP_MAXU]
                   | op_flags[`ALU_OP_MIN] | op_flags[`ALU_OP_MINU];

  assign maxmin_sel_op1 = ((op_flags[`ALU_OP_MAX] | op_flags[`ALU_OP_MAXU]) & ~op1_lt_op2)
                        | ((op_flags[`ALU_OP_MIN] | op_flags[`ALU_OP_MINU]) & op1_lt_op2);
  assign maxmin_res     = maxmin_sel_op1 ? mux_op1 : mux_op2.word;

  assign op_slttu = op_flags[`ALU_OP_SLT] | op_flags[`ALU_OP_SLTU];
  assign op_shift = op_flags[`ALU_OP_SLL] | op_flags[`ALU_OP_SRL] | op_flags[`ALU_OP_SRA];

  // One unit per flag, at most one flag high
  assign dpath_res =
      ({`ALU_XLEN{op_flags[`ALU_OP_OR]}}  & (mux_op1 | mux_op2.word))
    | ({`ALU_XLEN{op_flags[`ALU_OP_AND]}} & (mux_op1 & mux_op2.word))
    | ({`ALU_XLEN{op_flags[`ALU_OP_XOR]}} & xorer_res)
    | ({`ALU_XLEN{op_flags[`ALU_OP_ADD] | op_flags[`ALU_OP_SUB]}}
       & adder_res[`ALU_XLEN-1:0])
    | ({`ALU_XLEN{op_shift}}              & shift_res)
    | ({`ALU_XLEN{op_flags[`ALU_OP_MVOP2]}} & mux_op2.word)
    | ({`ALU_XLEN{op_slttu}} & {{(`ALU_XLEN-1){1'b0}}, op1_lt_op2})
    | ({`ALU_XLEN{op_maxmin}}             & maxmin_res)
    | ({`ALU_XLEN{op_flags[`ALU_OP_DOT]}} & dot_res);

endmodule

// File: design/alu_shared_buf.sv
/* Shared buffers
   Two enable-loaded 32-bit registers for the AGU */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_shared_buf (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sbf_0_ena,
  input  logic [`ALU_XLEN-1:0] sbf_0_nxt,
  input  logic                 sbf_1_ena,
  input  logic [`ALU_XLEN-1:0] sbf_1_nxt,
  output logic [`ALU_XLEN-1:0] sbf_0_r,
  output logic [`ALU_XLEN-1:0] sbf_1_r
);

  // Each buffer loads on its own enable, else holds
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sbf_0_r <= '0;
      sbf_1_r <= '0;
    end else begin
      if (sbf_0_ena) begin
        sbf_0_r <= sbf_0_nxt;
      end
      if (sbf_1_ena) begin
        sbf_1_r <= sbf_1_nxt;
      end
    end
  end

endmodule

// File: design/alu_dpath.sv
/* Shared integer ALU datapath
   ALU, BJP and AGU requests on one set of function units */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_dpath (
  input  logic                 clk,
  input  logic                 rst_n,
  // Regular ALU
  input  logic                 alu_req,
  input  logic                 alu_add,
  input  logic                 alu_sub,
  input  logic                 alu_xor,
  input  logic                 alu_sll,
  input  logic                 alu_srl,
  input  logic                 alu_sra,
  input  logic                 alu_or,
  input  logic                 alu_and,
  input  logic                 alu_slt,
  input  logic                 alu_sltu,
  input  logic                 alu_lui,
  input  logic                 alu_dot,
  input  logic [`ALU_XLEN-1:0] alu_op1,
  input  logic [`ALU_XLEN-1:0] alu_op2,
  input  logic [`ALU_XLEN-1:0] dot_a0,
  input  logic [`ALU_XLEN-1:0] dot_a1,
  input  logic [`ALU_XLEN-1:0] dot_a2,
  input  logic [`ALU_XLEN-1:0] dot_a3,
  input  logic [`ALU_XLEN-1:0] dot_a4,
  input  logic [`ALU_XLEN-1:0] dot_a5,
  input  logic [`ALU_XLEN-1:0] dot_a6,
  input  logic [`ALU_XLEN-1:0] dot_a7,
  // Branch unit
  input  logic                 bjp_req,
  input  logic [`ALU_XLEN-1:0] bjp_op1,
  input  logic [`ALU_XLEN-1:0] bjp_op2,
  input  logic                 bjp_add,
  input  logic                 bjp_cmp_eq,
  input  logic                 bjp_cmp_ne,
  input  logic                 bjp_cmp_lt,
  input  logic                 bjp_cmp_gt,
  input  logic                 bjp_cmp_ltu,
  input  logic                 bjp_cmp_gtu,
  // Address unit
  input  logic                 agu_req,
  input  logic [`ALU_XLEN-1:0] agu_op1,
  input  logic [`ALU_XLEN-1:0] agu_op2,
  input  logic                 agu_swap,
  input  logic                 agu_add,
  input  logic                 agu_and,
  input  logic                 agu_or,
  input  logic                 agu_xor,
  input  logic                 agu_max,
  input  logic                 agu_min,
  input  logic                 agu_maxu,
  input  logic                 agu_minu,
  // Shared buffers
  input  logic                 sbf_0_ena,
  input  logic [`ALU_XLEN-1:0] sbf_0_nxt,
  input  logic                 sbf_1_ena,
  input  logic [`ALU_XLEN-1:0] sbf_1_nxt,
  // Results, dpath_res serves all three requestors
  output logic [`ALU_XLEN-1:0] dpath_res,
  output logic                 cmp_res,
  output logic [`ALU_XLEN-1:0] sbf_0_r,
  output logic [`ALU_XLEN-1:0] sbf_1_r
);

  // Selected operands and flags
  logic [`ALU_XLEN-1:0]    mux_op1;
  alu_pkg::op2_u           mux_op2;
  logic [`ALU_OP_NUM-1:0]  op_flags;
  // Function unit results
  logic [`ALU_XLEN-1:0]    shift_res;
  logic [`ALU_ADDER_W-1:0] adder_res;
  logic [`ALU_XLEN-1:0]    dot_res;

  // Ports connect by matching names
  alu_req_mux    u_req_mux    (.*);
  alu_shifter    u_shifter    (.*);
  alu_adder      u_adder      (.*);
  alu_dot_unit   u_dot_unit   (.*);
  alu_result_mux u_result_mux (.*);

  // Buffers load on their enables alone, no requestor gating
  alu_shared_buf u_shared_buf (.*);

endmodule

// File: test/alu_dpath_checker.sv
/* Datapath checker
   Requestor exclusivity and shared buffer rules on the bound top */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_dpath_checker (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 alu_req,
  input logic                 bjp_req,
  input logic                 agu_req,
  input logic                 sbf_0_ena,
  input logic [`ALU_XLEN-1:0] sbf_0_nxt,
  input logic                 sbf_1_ena,
  input logic [`ALU_XLEN-1:0] sbf_1_nxt,
  input logic [`ALU_XLEN-1:0] sbf_0_r,
  input logic [`ALU_XLEN-1:0] sbf_1_r
);

  // Failed assertions so far
  int assert_fail_cnt = 0;

  // At most one requestor per cycle
  a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({alu_req, bjp_req, agu_req}))
    else begin
      $error("more than one requestor select high");
      assert_fail_cnt++;
    end

  // Buffers cleared during reset
  a_buf_rst: assert property (@(posedge clk)
    !rst_n |-> (sbf_0_r == '0 && sbf_1_r == '0))
    else begin
      $error("shared buffer not zero in reset");
      assert_fail_cnt++;
    end

  // Load shows up one cycle after the enable
  a_buf0_load: assert property (@(posedge clk) disable iff (!rst_n)
    sbf_0_ena |=> (sbf_0_r == $past(sbf_0_nxt)))
    else begin
      $error("buffer 0 did not load");
      assert_fail_cnt++;
    end

  a_buf1_load: assert property (@(posedge clk) disable iff (!rst_n)
    sbf_1_ena |=> (sbf_1_r == $past(sbf_1_nxt)))
    else begin
      $error("buffer 1 did not load");
      assert_fail_cnt++;
    end

endmodule

bind alu_dpath alu_dpath_checker u_checker (.*);

// File: test/alu_dpath_tb.sv
/* ALU datapath testbench
   Vector file stimulus with random idle cycles between vectors */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_dpath_tb;

  localparam int          CLK_PERIOD = 8;
  localparam logic [31:0] SEED       = 32'h4a1d;
  localparam string       VEC_FILE   = "test/alu_dpath_input.txt";
  // Words per vector line
  localparam int          VEC_W      = 14;
  localparam int          MAX_VEC    = 64;

  logic clk;
  logic rst_n;
  logic alu_req, alu_add, alu_sub, alu_xor, alu_sll, alu_srl, alu_sra;
  logic alu_or, alu_and, alu_slt, alu_sltu, alu_lui, alu_dot;
  logic [31:0] alu_op1, alu_op2;
  logic [31:0] dot_a0, dot_a1, dot_a2, dot_a3, dot_a4, dot_a5, dot_a6, dot_a7;
  logic bjp_req, bjp_add, bjp_cmp_eq, bjp_cmp_ne, bjp_cmp_lt, bjp_cmp_gt;
  logic bjp_cmp_ltu, bjp_cmp_gtu;
  logic [31:0] bjp_op1, bjp_op2;
  logic agu_req, agu_swap, agu_add, agu_and, agu_or, agu_xor;
  logic agu_max, agu_min, agu_maxu, agu_minu;
  logic [31:0] agu_op1, agu_op2;
  logic sbf_0_ena, sbf_1_ena;
  logic [31:0] sbf_0_nxt, sbf_1_nxt;
  logic [31:0] dpath_res;
  logic        cmp_res;
  logic [31:0] sbf_0_r, sbf_1_r;

  logic [31:0] vec_mem [0:MAX_VEC*VEC_W-1];
  int          num_vec;
  int          err_cnt;
  int          check_cnt;

  alu_dpath u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic clear_inputs();
    {alu_req, alu_add, alu_sub, alu_xor, alu_sll, alu_srl, alu_sra} = '0;
    {alu_or, alu_and, alu_slt, alu_sltu, alu_lui, alu_dot} = '0;
    {bjp_req, bjp_add, bjp_cmp_eq, bjp_cmp_ne, bjp_cmp_lt, bjp_cmp_gt} = '0;
    {bjp_cmp_ltu, bjp_cmp_gtu} = '0;
    {agu_req, agu_swap, agu_add, agu_and, agu_or, agu_xor} = '0;
    {agu_max, agu_min, agu_maxu, agu_minu} = '0;
    {alu_op1, alu_op2, bjp_op1, bjp_op2, agu_op1, agu_op2} = '0;
    {dot_a0, dot_a1, dot_a2, dot_a3, dot_a4, dot_a5, dot_a6, dot_a7} = '0;
    {sbf_0_ena, sbf_1_ena, sbf_0_nxt, sbf_1_nxt} = '0;
  endtask

  // Idle cycle with random operands and flags but no select
  task automatic drive_idle_random();
    logic [31:0] r;
    clear_inputs();
    r = $urandom();
    {alu_add, alu_sub, alu_xor, alu_sll, alu_srl, alu_sra, alu_or} = r[6:0];
    {alu_and, alu_slt, alu_sltu, alu_lui, alu_dot} = r[11:7];
    {bjp_add, bjp_cmp_eq, bjp_cmp_ne, bjp_cmp_lt, bjp_cmp_gt} = r[16:12];
    {bjp_cmp_ltu, bjp_cmp_gtu, agu_swap, agu_add, agu_and} = r[21:17];
    {agu_or, agu_xor, agu_max, agu_min, agu_maxu, agu_minu} = r[27:22];
    alu_op1 = $urandom();
    alu_op2 = $urandom();
    bjp_op1 = $urandom();
    bjp_op2 = $urandom();
    agu_op1 = $urandom();
    agu_op2 = $urandom();
    dot_a0  = $urandom();
    dot_a4  = $urandom();
    sbf_0_nxt = $urandom();
    sbf_1_nxt = $urandom();
  endtask

  // Flag index to port for each requestor code
  task automatic apply_flag(input int req, input int flag);
    if (req == 0 || req == 1) begin
      case (flag)
        `ALU_OP_ADD:   alu_add  = 1'b1;
        `ALU_OP_SUB:   alu_sub  = 1'b1;
        `ALU_OP_OR:    alu_or   = 1'b1;
        `ALU_OP_XOR:   alu_xor  = 1'b1;
        `ALU_OP_AND:   alu_and  = 1'b1;
        `ALU_OP_SLL:   alu_sll  = 1'b1;
        `ALU_OP_SRL:   alu_srl  = 1'b1;
        `ALU_OP_SRA:   alu_sra  = 1'b1;
        `ALU_OP_SLT:   alu_slt  = 1'b1;
        `ALU_OP_SLTU:  alu_sltu = 1'b1;
        `ALU_OP_MVOP2: alu_lui  = 1'b1;
        `ALU_OP_DOT:   alu_dot  = 1'b1;
        default: ;
      endcase
    end
    if (req == 0 || req == 2) begin
      case (flag)
        `ALU_OP_ADD:     bjp_add     = 1'b1;
        `ALU_OP_CMP_EQ:  bjp_cmp_eq  = 1'b1;
        `ALU_OP_CMP_NE:  bjp_cmp_ne  = 1'b1;
        `ALU_OP_CMP_LT:  bjp_cmp_lt  = 1'b1;
        `ALU_OP_CMP_GT:  bjp_cmp_gt  = 1'b1;
        `ALU_OP_CMP_LTU: bjp_cmp_ltu = 1'b1;
        `ALU_OP_CMP_GTU: bjp_cmp_gtu = 1'b1;
        default: ;
      endcase
    end
    if (req == 0 || req == 3) begin
      case (flag)
        `ALU_OP_MVOP2: agu_swap = 1'b1;
        `ALU_OP_ADD:   agu_add  = 1'b1;
        `ALU_OP_AND:   agu_and  = 1'b1;
        `ALU_OP_OR:    agu_or   = 1'b1;
        `ALU_OP_XOR:   agu_xor  = 1'b1;
        `ALU_OP_MAX:   agu_max  = 1'b1;
        `ALU_OP_MIN:   agu_min  = 1'b1;
        `ALU_OP_MAXU:  agu_maxu = 1'b1;
        `ALU_OP_MINU:  agu_minu = 1'b1;
        default: ;
      endcase
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("mismatch %s got %h expected %h", name, got, exp);
    end
  endtask

  // Sample point just before the next falling edge
  task automatic wait_sample();
    @(posedge clk);
    #(CLK_PERIOD/2 - 1);
  endtask

  task automatic run_vector(input int v);
    int          base;
    int          req;
    logic [31:0] exp_res;
    base    = v * VEC_W;
    req     = int'(vec_mem[base]);
    exp_res = vec_mem[base+12];
    @(negedge clk);
    clear_inputs();
    if (req == 4) begin
      if (vec_mem[base+1] == 0) begin
        sbf_0_ena = 1'b1;
        sbf_0_nxt = vec_mem[base+2];
      end else begin
        sbf_1_ena = 1'b1;
        sbf_1_nxt = vec_mem[base+2];
      end
      // Loaded value shows after the first edge and holds over two idle cycles
      for (int i = 0; i < 3; i++) begin
        if (i > 0) begin
          @(negedge clk);
          drive_idle_random();
        end
        wait_sample();
        if (vec_mem[base+1] == 0) begin
          check_word("sbf_0_r", sbf_0_r, exp_res);
        end else begin
          check_word("sbf_1_r", sbf_1_r, exp_res);
        end
      end
    end else begin
      {alu_op1, bjp_op1, agu_op1} = {3{vec_mem[base+2]}};
      {alu_op2, bjp_op2, agu_op2} = {3{vec_mem[base+3]}};
      {dot_a0, dot_a1, dot_a2, dot_a3} = {vec_mem[base+4], vec_mem[base+5],
                                          vec_mem[base+6], vec_mem[base+7]};
      {dot_a4, dot_a5, dot_a6, dot_a7} = {vec_mem[base+8], vec_mem[base+9],
                                          vec_mem[base+10], vec_mem[base+11]};
      alu_req = (req == 1);
      bjp_req = (req == 2);
      agu_req = (req == 3);
      apply_flag(req, int'(vec_mem[base+1]));
      wait_sample();
      check_word("dpath_res", dpath_res, exp_res);
      check_word("cmp_res", {31'd0, cmp_res}, vec_mem[base+13]);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    err_cnt   = 0;
    check_cnt = 0;
    num_vec   = 0;
    rst_n     = 1'b1;
    clear_inputs();
    $readmemh(VEC_FILE, vec_mem);
    // End marker line has requestor code ff
    while (num_vec < MAX_VEC && vec_mem[num_vec*VEC_W] != 32'hff) num_vec++;
    #1 rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    wait_sample();
    check_word("sbf_0_r", sbf_0_r, 32'h0);
    check_word("sbf_1_r", sbf_1_r, 32'h0);
    for (int v = 0; v < num_vec; v++) begin
      run_vector(v);
      @(negedge clk);
      drive_idle_random();
      wait_sample();
      check_word("dpath_res", dpath_res, 32'h0);
      check_word("cmp_res", {31'd0, cmp_res}, 32'h0);
    end
    $display("%0d vectors, %0d checks, %0d errors, %0d assertion failures",
             num_vec, check_cnt, err_cnt, u_dut.u_checker.assert_fail_cnt);
    if (err_cnt == 0 && u_dut.u_checker.assert_fail_cnt == 0 && num_vec > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (num_vec > 0);
    #((num_vec * 4 + 50) * CLK_PERIOD);
    $display("watchdog expired before the vectors finished");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: src.f
+incdir+design
design/alu_pkg.sv
design/alu_req_mux.sv
design/alu_shifter.sv
design/alu_adder.sv
design/alu_dot_unit.sv
design/alu_result_mux.sv
design/alu_shared_buf.sv
design/alu_dpath.sv
test/alu_dpath_checker.sv
test/alu_dpath_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the ALU datapath testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f src.f \
  --top-module alu_dpath_tb

./obj_dir/Valu_dpath_tb | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  exit 0
fi
exit 1

// File: test/alu_dpath_input.txt
// req(0 none 1 alu 2 bjp 3 agu 4 buf) flag op1 op2 a0..a7 exp_res exp_cmp
// Flag is the op-flag index, or the buffer number for req 4; ff ends the list
1 0 7fffffff 00000001 0 0 0 0 0 0 0 0 80000000 0
1 1 00000005 00000007 0 0 0 0 0 0 0 0 fffffffe 0
1 2 f0f00000 0000ff0f 0 0 0 0 0 0 0 0 f0f0ff0f 0
1 3 aaaa5555 ffff0000 0 0 0 0 0 0 0 0 55555555 0
1 4 12345678 0f0f0f0f 0 0 0 0 0 0 0 0 02040608 0
1 5 00000001 0000001f 0 0 0 0 0 0 0 0 80000000 0
1 5 89abcdef ffffffe0 0 0 0 0 0 0 0 0 89abcdef 0
1 6 80000000 0000001f 0 0 0 0 0 0 0 0 00000001 0
1 6 f0000000 00000004 0 0 0 0 0 0 0 0 0f000000 0
1 7 80000000 0000001f 0 0 0 0 0 0 0 0 ffffffff 0
1 7 f0000010 00000004 0 0 0 0 0 0 0 0 ff000001 0
1 7 80000001 00000000 0 0 0 0 0 0 0 0 80000001 0
1 8 ffffffff 00000001 0 0 0 0 0 0 0 0 00000001 0
1 9 ffffffff 00000001 0 0 0 0 0 0 0 0 00000000 0
1 9 00000001 ffffffff 0 0 0 0 0 0 0 0 00000001 0
1 a 12345678 abcde000 0 0 0 0 0 0 0 0 abcde000 0
1 f 0 0 1 2 3 4 5 6 7 8 00000046 0
1 f 0 0 ffffffff 80000000 10000 3 ffffffff 2 10000 55555556 00000003 0
2 10 00001234 00001234 0 0 0 0 0 0 0 0 00000000 1
2 10 00000001 00000002 0 0 0 0 0 0 0 0 00000000 0
2 11 00001234 00001235 0 0 0 0 0 0 0 0 00000000 1
2 12 ffffffff 00000001 0 0 0 0 0 0 0 0 00000000 1
2 14 ffffffff 00000001 0 0 0 0 0 0 0 0 00000000 0
2 13 00000001 ffffffff 0 0 0 0 0 0 0 0 00000000 1
2 15 00000001 ffffffff 0 0 0 0 0 0 0 0 00000000 0
2 0 80000000 00001000 0 0 0 0 0 0 0 0 80001000 0
3 b ffffffff 00000001 0 0 0 0 0 0 0 0 00000001 0
3 c ffffffff 00000001 0 0 0 0 0 0 0 0 ffffffff 0
3 d ffffffff 00000001 0 0 0 0 0 0 0 0 ffffffff 0
3 e ffffffff 00000001 0 0 0 0 0 0 0 0 00000001 0
3 a 11111111 22222222 0 0 0 0 0 0 0 0 22222222 0
3 0 00000010 fffffff0 0 0 0 0 0 0 0 0 00000000 0
3 3 0f0f0f0f 00ff00ff 0 0 0 0 0 0 0 0 0ff00ff0 0
3 4 ff00ff00 0ff00ff0 0 0 0 0 0 0 0 0 0f000f00 0
3 2 ff00ff00 0ff00ff0 0 0 0 0 0 0 0 0 fff0fff0 0
0 0 ffffffff 00000001 0 0 0 0 0 0 0 0 00000000 0
0 f 0 0 1 2 3 4 5 6 7 8 00000000 0
0 10 00001234 00001234 0 0 0 0 0 0 0 0 00000000 0
4 0 deadbeef 0 0 0 0 0 0 0 0 0 deadbeef 0
4 1 13572468 0 0 0 0 0 0 0 0 0 13572468 0
ff 0 0 0 0 0 0 0 0 0 0 0 0 0
